//--- common/amber_pkg.sv
package amber_pkg;

    // ------------------------------------------------------------------------
    // Widths and basic types
    // ------------------------------------------------------------------------
    localparam int DATA_W  = 24;
    localparam int OPC_W   = 6;
    localparam int GP_W    = 4;
    localparam int NUM_GP  = 16;

    // Only the low bits of the rb value are taken as the shift count
    localparam int SHAMT_W = 5;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [DATA_W-1:0] instr_t;
    typedef logic [OPC_W-1:0]  opc_t;
    typedef logic [GP_W-1:0]   gp_idx_t;

    // ------------------------------------------------------------------------
    // Instruction field positions
    // ------------------------------------------------------------------------
    localparam int OPC_HI   = 23;
    localparam int OPC_LO   = 18;
    localparam int RD_HI    = 17;
    localparam int RD_LO    = 14;
    localparam int RA_HI    = 13;
    localparam int RA_LO    = 10;
    localparam int RB_HI    = 9;
    localparam int RB_LO    = 6;

    // Both immediates start at bit 0
    localparam int IMM10_HI = 9;
    localparam int IMM14_HI = 13;

    // ------------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------------
    localparam opc_t OPC_NOP  = 6'h00;
    localparam opc_t OPC_ADD  = 6'h01;
    localparam opc_t OPC_SUB  = 6'h02;
    localparam opc_t OPC_AND  = 6'h03;
    localparam opc_t OPC_OR   = 6'h04;
    localparam opc_t OPC_XOR  = 6'h05;
    localparam opc_t OPC_SHL  = 6'h06;
    localparam opc_t OPC_SHR  = 6'h07;
    localparam opc_t OPC_ADDI = 6'h08;
    localparam opc_t OPC_MOVI = 6'h09;

    // ------------------------------------------------------------------------
    // Stage payloads
    // ------------------------------------------------------------------------

    // Decoded instruction, imm already extended
    typedef struct packed {
        opc_t    opc;
        gp_idx_t rd;
        gp_idx_t ra;
        gp_idx_t rb;
        data_t   imm;
        logic    wr_en;
    } dec_t;

    // One result on its way to the register file
    typedef struct packed {
        gp_idx_t rd;
        data_t   value;
        logic    wr_en;
    } retire_t;

endpackage

//--- hdl/amber_core.sv
module amber_core (
    input  logic               iw_clk,
    input  logic               iw_rst,

    // Instruction input
    input  logic               in_valid,
    output logic               in_ready,
    input  amber_pkg::instr_t  in_instr,

    // Retire port
    output logic               retire_valid,
    input  logic               retire_ready,
    output amber_pkg::retire_t retire
);

    // ------------------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------------------
    logic               dec_valid;
    logic               dec_ready;
    amber_pkg::dec_t    dec;

    logic               res_valid;
    logic               res_ready;
    amber_pkg::retire_t res;

    // Register file
    amber_pkg::gp_idx_t rd_addr_a;
    amber_pkg::gp_idx_t rd_addr_b;
    amber_pkg::data_t   rd_data_a;
    amber_pkg::data_t   rd_data_b;
    logic               gp_we;
    amber_pkg::gp_idx_t gp_waddr;
    amber_pkg::data_t   gp_wdata;

    stg_id u_stg_id (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec       (dec)
    );

    // Writeback's held item doubles as the second forwarding source
    stg_ex u_stg_ex (
        .iw_clk           (iw_clk),
        .iw_rst           (iw_rst),
        .dec_valid        (dec_valid),
        .dec_ready        (dec_ready),
        .dec              (dec),
        .rd_addr_a        (rd_addr_a),
        .rd_addr_b        (rd_addr_b),
        .rd_data_a        (rd_data_a),
        .rd_data_b        (rd_data_b),
        .wb_pending       (retire),
        .wb_pending_valid (retire_valid),
        .res_valid        (res_valid),
        .res_ready        (res_ready),
        .res              (res)
    );

    stg_wb u_stg_wb (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .res          (res),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire),
        .gp_we        (gp_we),
        .gp_waddr     (gp_waddr),
        .gp_wdata     (gp_wdata)
    );

    reg_gp u_reg_gp (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .gp_we     (gp_we),
        .gp_waddr  (gp_waddr),
        .gp_wdata  (gp_wdata)
    );

endmodule

//--- hdl/reg_gp.sv
module reg_gp (
    input  logic               iw_clk,
    input  logic               iw_rst,
    input  amber_pkg::gp_idx_t rd_addr_a,
    input  amber_pkg::gp_idx_t rd_addr_b,
    output amber_pkg::data_t   rd_data_a,
    output amber_pkg::data_t   rd_data_b,
    input  logic               gp_we,
    input  amber_pkg::gp_idx_t gp_waddr,
    input  amber_pkg::data_t   gp_wdata
);

    amber_pkg::data_t regs [amber_pkg::NUM_GP];

    // Asynchronous reads, no bypass of the write port
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < amber_pkg::NUM_GP; i++) begin
                regs[i] <= '0;
            end
        end else if (gp_we) begin
            regs[gp_waddr] <= gp_wdata;
        end
    end

endmodule

//--- hdl/stg_ex.sv
module stg_ex (
    input  logic                iw_clk,
    input  logic                iw_rst,

    // Decoded instruction from stg_id
    input  logic                dec_valid,
    output logic                dec_ready,
    input  amber_pkg::dec_t     dec,

    // Register file read port
    output amber_pkg::gp_idx_t  rd_addr_a,
    output amber_pkg::gp_idx_t  rd_addr_b,
    input  amber_pkg::data_t    rd_data_a,
    input  amber_pkg::data_t    rd_data_b,

    // Item held in writeback, not yet in the register file
    input  amber_pkg::retire_t  wb_pending,
    input  logic                wb_pending_valid,

    // Result towards writeback
    output logic                res_valid,
    input  logic                res_ready,
    output amber_pkg::retire_t  res
);

    logic                     ex_hit_a;
    logic                     ex_hit_b;
    logic                     wb_hit_a;
    logic                     wb_hit_b;
    amber_pkg::data_t         op_a;
    amber_pkg::data_t         op_b;
    logic [amber_pkg::SHAMT_W-1:0] shamt;
    logic                     shift_out;
    amber_pkg::retire_t       res_next;

    assign rd_addr_a = dec.ra;
    assign rd_addr_b = dec.rb;

    // ------------------------------------------------------------------------
    // Operand forwarding
    // ------------------------------------------------------------------------

    // Own held result is the youngest, so it wins over writeback
    assign ex_hit_a = res_valid && res.wr_en && (res.rd == dec.ra);
    assign ex_hit_b = res_valid && res.wr_en && (res.rd == dec.rb);
    assign wb_hit_a = wb_pending_valid && wb_pending.wr_en && (wb_pending.rd == dec.ra);
    assign wb_hit_b = wb_pending_valid && wb_pending.wr_en && (wb_pending.rd == dec.rb);

    assign op_a = ex_hit_a ? res.value :
                  wb_hit_a ? wb_pending.value : rd_data_a;
    assign op_b = ex_hit_b ? res.value :
                  wb_hit_b ? wb_pending.value : rd_data_b;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    assign shamt     = op_b[amber_pkg::SHAMT_W-1:0];
    assign shift_out = (shamt >= amber_pkg::DATA_W);

    always_comb begin
        res_next.rd    = dec.rd;
        res_next.wr_en = dec.wr_en;
        case (dec.opc)
            amber_pkg::OPC_ADD:  res_next.value = op_a + op_b;
            amber_pkg::OPC_SUB:  res_next.value = op_a - op_b;
            amber_pkg::OPC_AND:  res_next.value = op_a & op_b;
            amber_pkg::OPC_OR:   res_next.value = op_a | op_b;
            amber_pkg::OPC_XOR:  res_next.value = op_a ^ op_b;
            amber_pkg::OPC_SHL:  res_next.value = shift_out ? '0 : (op_a << shamt);
            amber_pkg::OPC_SHR:  res_next.value = shift_out ? '0 : (op_a >> shamt);
            amber_pkg::OPC_ADDI: res_next.value = op_a + dec.imm;
            amber_pkg::OPC_MOVI: res_next.value = dec.imm;
            // NOP and unknown opcodes
            default:             res_next.value = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Holding register
    // ------------------------------------------------------------------------
    assign dec_ready = !res_valid || res_ready;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            res_valid <= 1'b0;
        end else if (dec_ready) begin
            res_valid <= dec_valid;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (dec_valid && dec_ready) begin
            res <= res_next;
        end
    end

endmodule

//--- hdl/stg_id.sv
module stg_id (
    input  logic              iw_clk,
    input  logic              iw_rst,

    // Instruction input
    input  logic              in_valid,
    output logic              in_ready,
    input  amber_pkg::instr_t in_instr,

    // Decoded instruction towards execute
    output logic              dec_valid,
    input  logic              dec_ready,
    output amber_pkg::dec_t   dec
);

    amber_pkg::opc_t  opc;
    amber_pkg::data_t imm_sx10;
    amber_pkg::data_t imm_zx14;
    amber_pkg::dec_t  dec_next;

    // ------------------------------------------------------------------------
    // Field slicing
    // ------------------------------------------------------------------------
    assign opc = in_instr[amber_pkg::OPC_HI:amber_pkg::OPC_LO];

    assign imm_sx10 = {{(amber_pkg::DATA_W - amber_pkg::IMM10_HI - 1){in_instr[amber_pkg::IMM10_HI]}},
                       in_instr[amber_pkg::IMM10_HI:0]};
    assign imm_zx14 = {{(amber_pkg::DATA_W - amber_pkg::IMM14_HI - 1){1'b0}},
                       in_instr[amber_pkg::IMM14_HI:0]};

    always_comb begin
        dec_next.opc = opc;
        dec_next.rd  = in_instr[amber_pkg::RD_HI:amber_pkg::RD_LO];
        dec_next.ra  = in_instr[amber_pkg::RA_HI:amber_pkg::RA_LO];
        dec_next.rb  = in_instr[amber_pkg::RB_HI:amber_pkg::RB_LO];

        // Only ADDI and MOVI carry an immediate
        case (opc)
            amber_pkg::OPC_ADDI: dec_next.imm = imm_sx10;
            amber_pkg::OPC_MOVI: dec_next.imm = imm_zx14;
            default:             dec_next.imm = '0;
        endcase

        // NOP and anything above MOVI leave the register file alone
        dec_next.wr_en = (opc >= amber_pkg::OPC_ADD) && (opc <= amber_pkg::OPC_MOVI);
    end

    // ------------------------------------------------------------------------
    // Holding register
    // ------------------------------------------------------------------------

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !dec_valid || dec_ready;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (in_valid && in_ready) begin
            dec <= dec_next;
        end
    end

endmodule

//--- hdl/stg_wb.sv
module stg_wb (
    input  logic               iw_clk,
    input  logic               iw_rst,

    // Result from execute
    input  logic               res_valid,
    output logic               res_ready,
    input  amber_pkg::retire_t res,

    // Retire port
    output logic               retire_valid,
    input  logic               retire_ready,
    output amber_pkg::retire_t retire,

    // Register file write port
    output logic               gp_we,
    output amber_pkg::gp_idx_t gp_waddr,
    output amber_pkg::data_t   gp_wdata
);

    assign res_ready = !retire_valid || retire_ready;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            retire_valid <= 1'b0;
        end else if (res_ready) begin
            retire_valid <= res_valid;
        end
    end

    // Payload only changes when the slot is free, so it holds under a stall
    always_ff @(posedge iw_clk) begin
        if (res_valid && res_ready) begin
            retire <= res;
        end
    end

    // Write lands on the same edge the item retires
    assign gp_we    = retire_valid && retire_ready && retire.wr_en;
    assign gp_waddr = retire.rd;
    assign gp_wdata = retire.value;

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_amber \
    -f sources.f -o tb_amber_sim || exit 1
result=$(./obj_dir/tb_amber_sim)
echo "$result"
echo "$result" | grep -qx "TEST RESULT: PASS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- sources.f
common/amber_pkg.sv
hdl/reg_gp.sv
hdl/stg_id.sv
hdl/stg_ex.sv
hdl/stg_wb.sv
hdl/amber_core.sv
test/clk_gen.sv
test/amber_checker.sv
test/tb_amber.sv

//--- test/amber_checker.sv
module amber_checker (
    input  logic               iw_clk,
    input  logic               iw_rst,
    input  logic               in_valid,
    input  logic               in_ready,
    input  amber_pkg::instr_t  in_instr,
    input  logic               retire_valid,
    input  logic               retire_ready,
    input  amber_pkg::retire_t retire,
    input  logic               lat_check,
    output int                 cmp_errors,
    output int                 proto_errors,
    output int                 accept_count,
    output int                 retire_count,
    output int                 pending
);
    timeunit 1ns;
    timeprecision 1ps;

    amber_pkg::data_t   model [16];
    amber_pkg::retire_t exp_q [$];
    int                 acc_q [$];
    int                 cycle;
    logic               stalled;

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic amber_pkg::data_t imm_of(input amber_pkg::instr_t ins);
        if (ins[23:18] == amber_pkg::OPC_ADDI) return {{14{ins[9]}}, ins[9:0]};
        if (ins[23:18] == amber_pkg::OPC_MOVI) return {10'h000, ins[13:0]};
        return '0;
    endfunction

    function automatic amber_pkg::retire_t ref_result(
        input amber_pkg::opc_t    opc,
        input amber_pkg::gp_idx_t rd,
        input amber_pkg::data_t   a,
        input amber_pkg::data_t   b,
        input amber_pkg::data_t   imm
    );
        amber_pkg::retire_t r;
        r.rd    = rd;
        r.wr_en = 1'b1;
        case (opc)
            amber_pkg::OPC_ADD:  r.value = a + b;
            amber_pkg::OPC_SUB:  r.value = a - b;
            amber_pkg::OPC_AND:  r.value = a & b;
            amber_pkg::OPC_OR:   r.value = a | b;
            amber_pkg::OPC_XOR:  r.value = a ^ b;
            // Counts of 24 to 31 shift everything out
            amber_pkg::OPC_SHL:  r.value = (b[4:0] > 5'd23) ? '0 : a << b[4:0];
            amber_pkg::OPC_SHR:  r.value = (b[4:0] > 5'd23) ? '0 : a >> b[4:0];
            amber_pkg::OPC_ADDI: r.value = a + imm;
            amber_pkg::OPC_MOVI: r.value = imm;
            default: begin
                r.value = '0;
                r.wr_en = 1'b0;
            end
        endcase
        return r;
    endfunction

    task automatic compare(input string name, input logic [23:0] exp_v, input logic [23:0] act_v);
        if (act_v !== exp_v) begin
            $display("Fail %s: expected 0x%0h, actual 0x%0h at %0t", name, exp_v, act_v, $time);
            cmp_errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Port monitor sampled on the rising edge where handshakes complete
    // ------------------------------------------------------------------------
    always @(posedge iw_clk) begin
        amber_pkg::retire_t exp_item;
        int                 acc;
        if (iw_rst) begin
            foreach (model[i]) model[i] = '0;
            exp_q.delete();
            acc_q.delete();
            cycle        = 0;
            stalled      = 1'b0;
            cmp_errors   = 0;
            proto_errors = 0;
            accept_count = 0;
            retire_count = 0;
            pending      = 0;
        end else begin
            if (cycle == 0 && (retire_valid !== 1'b0 || in_ready !== 1'b1)) begin
                $display("Error: after reset retire_valid=%b and in_ready=%b",
                         retire_valid, in_ready);
                proto_errors++;
            end
            cycle++;
            if (stalled && !retire_valid) begin
                $display("Error: retire_valid dropped while retire_ready was low at %0t", $time);
                proto_errors++;
            end
            // A stalled item must still be the oldest outstanding one
            if (retire_valid && !retire_ready && exp_q.size() != 0) begin
                exp_item = exp_q[0];
                compare("retire.rd", 24'(exp_item.rd), 24'(retire.rd));
                compare("retire.value", exp_item.value, retire.value);
                compare("retire.wr_en", 24'(exp_item.wr_en), 24'(retire.wr_en));
            end
            stalled = retire_valid && !retire_ready;
            if (lat_check && in_valid && !in_ready) begin
                $display("Error: in_ready low during continuous issue at %0t", $time);
                proto_errors++;
            end
            if (retire_valid && retire_ready) begin
                retire_count++;
                if (exp_q.size() == 0) begin
                    $display("Error: retire with no outstanding instruction at %0t", $time);
                    proto_errors++;
                end else begin
                    exp_item = exp_q.pop_front();
                    acc      = acc_q.pop_front();
                    compare("retire.rd", 24'(exp_item.rd), 24'(retire.rd));
                    compare("retire.value", exp_item.value, retire.value);
                    compare("retire.wr_en", 24'(exp_item.wr_en), 24'(retire.wr_en));
                    if (lat_check && cycle - acc - 1 != 2) begin
                        $display("Error: instruction took %0d cycles to retire_valid, not 2",
                                 cycle - acc - 1);
                        proto_errors++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_item = ref_result(in_instr[23:18], in_instr[17:14], model[in_instr[13:10]],
                                      model[in_instr[9:6]], imm_of(in_instr));
                // Retirement is in order, so the model can run ahead
                if (exp_item.wr_en) model[exp_item.rd] = exp_item.value;
                exp_q.push_back(exp_item);
                acc_q.push_back(cycle);
                accept_count++;
            end
            pending = exp_q.size();
        end
    end

endmodule

//--- test/clk_gen.sv
module clk_gen (
    output logic iw_clk,
    output logic iw_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 5;
    localparam int RST_CYCLES  = 8;

    initial begin
        iw_clk = 1'b0;
        forever #(HALF_PERIOD) iw_clk = ~iw_clk;
    end

    // Release lands on a rising edge, so flops still see reset on that edge
    initial begin
        iw_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge iw_clk);
        iw_rst <= 1'b0;
    end

endmodule

//--- test/tb_amber.sv
module tb_amber;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CHAIN     = 20;
    localparam int N_RAND      = 1200;
    localparam int N_BP        = 500;
    localparam int N_LAT       = 100;
    localparam int N_UNK       = 40;
    localparam int N_TOTAL     = 32 + 5 * N_CHAIN + N_RAND + N_BP + N_LAT + 3 * N_UNK;
    localparam int WATCHDOG_NS = (N_TOTAL * 4 + 200) * 10;

    logic               iw_clk;
    logic               iw_rst;
    logic               in_valid;
    logic               in_ready;
    amber_pkg::instr_t  in_instr;
    logic               retire_valid;
    logic               retire_ready;
    amber_pkg::retire_t retire;
    logic               lat_check;
    logic               bp_mode;
    logic [31:0]        rng_state;
    int                 cmp_errors;
    int                 proto_errors;
    int                 accept_count;
    int                 retire_count;
    int                 pending;

    clk_gen u_clk_gen (.iw_clk(iw_clk), .iw_rst(iw_rst));

    amber_core u_amber_core (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    amber_checker u_checker (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire),
        .lat_check    (lat_check),
        .cmp_errors   (cmp_errors),
        .proto_errors (proto_errors),
        .accept_count (accept_count),
        .retire_count (retire_count),
        .pending      (pending)
    );

    // ------------------------------------------------------------------------
    // Stimulus helpers, all driving happens on the falling edge
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_rand(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    task automatic next_cycle();
        logic [31:0] r;
        @(negedge iw_clk);
        if (bp_mode) begin
            draw_rand(r);
            retire_ready = r[3];
        end else begin
            retire_ready = 1'b1;
        end
    endtask

    // Hold the instruction until in_ready is seen ahead of a rising edge
    task automatic send_instr(input amber_pkg::instr_t instr);
        logic taken;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_instr = instr;
        while (!taken) begin
            #2;
            taken = in_ready;
            next_cycle();
        end
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (pending != 0) next_cycle();
    endtask

    task automatic init_registers();
        for (int n = 0; n < 16; n++) begin
            send_instr({amber_pkg::OPC_MOVI, 4'(n), 14'(n * 291 + 17)});
        end
        // r0 last, so every sum uses its MOVI value
        for (int n = 15; n >= 0; n--) begin
            send_instr({amber_pkg::OPC_ADD, 4'(n), 4'(n), 4'h0, 6'h00});
        end
    endtask

    task automatic forwarding_chains();
        logic [31:0] r;
        logic [31:0] s;
        repeat (N_CHAIN) begin
            draw_rand(r);
            draw_rand(s);
            send_instr({amber_pkg::OPC_MOVI, r[3:0], s[13:0]});
            send_instr({amber_pkg::OPC_ADDI, r[3:0], r[3:0], s[25:16]});
            send_instr({amber_pkg::OPC_SUB, r[7:4], r[3:0], r[15:12], 6'h00});
            send_instr({amber_pkg::OPC_SHL, r[11:8], r[7:4], r[3:0], 6'h00});
            send_instr({amber_pkg::OPC_XOR, r[15:12], r[11:8], r[7:4], 6'h00});
        end
    endtask

    task automatic random_mix(input int count, input logic gaps);
        logic [31:0] r;
        logic [31:0] s;
        repeat (count) begin
            draw_rand(r);
            draw_rand(s);
            if (gaps && s[9:8] == 2'b00) begin
                in_valid = 1'b0;
                next_cycle();
            end
            send_instr({amber_pkg::opc_t'(s % 32'd10), r[17:0]});
        end
    endtask

    task automatic unknown_opcodes();
        logic [31:0] r;
        logic [31:0] s;
        repeat (N_UNK) begin
            draw_rand(r);
            draw_rand(s);
            send_instr({amber_pkg::OPC_MOVI, r[3:0], s[13:0]});
            send_instr({amber_pkg::opc_t'(32'd10 + r[31:16] % 32'd54), r[3:0], s[27:14]});
            // Read back the target through OR with itself
            send_instr({amber_pkg::OPC_OR, r[7:4], r[3:0], r[3:0], 6'h00});
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic failed;
        in_valid     = 1'b0;
        in_instr     = '0;
        retire_ready = 1'b1;
        lat_check    = 1'b0;
        bp_mode      = 1'b0;
        rng_state    = 32'h6bba787c;
        next_cycle();
        while (iw_rst) next_cycle();

        init_registers();
        drain();
        forwarding_chains();
        drain();
        random_mix(N_RAND, 1'b0);
        drain();
        bp_mode = 1'b1;
        random_mix(N_BP, 1'b1);
        drain();
        bp_mode = 1'b0;
        next_cycle();
        lat_check = 1'b1;
        random_mix(N_LAT, 1'b0);
        drain();
        lat_check = 1'b0;
        unknown_opcodes();
        drain();

        failed = (cmp_errors != 0) || (proto_errors != 0) || (accept_count != retire_count);
        if (accept_count != retire_count) begin
            $display("Error: %0d instructions accepted but %0d retired", accept_count, retire_count);
        end
        $display("Summary: %0d compare errors, %0d protocol errors, %0d accepted, %0d retired",
                 cmp_errors, proto_errors, accept_count, retire_count);
        if (!failed) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns, %0d instructions outstanding",
                 WATCHDOG_NS, pending);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
